// File: bpi_interface_top.f
source/bpi_pkg.sv
source/bpi_cmd_if.sv
source/bpi_cmd_capture.sv
source/bpi_cycle_fsm.sv
source/led_pattern_gen.sv
source/startup_display_fsm.sv
source/bpi_interface_top.sv
verif/bpi_checker.sv
verif/bpi_monitor.sv
verif/bpi_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the BPI interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f bpi_interface_top.f \
  --top-module bpi_tb -Mdir obj_dir -o bpi_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/bpi_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: verif/bpi_golden.txt
// Five hex words per record: kind op addr data word
// kind 1 host cycle, 2 auto-load cycle, 3 host cycle with extra EXECUTE, 4 display, 5 status, 0 end
00000001 00000001 00000123 0000BEEF 00000000
00000001 00000002 001ABCDE 00000000 00005A3C
00000002 00000001 000055AA 0000C0DE 00000000
00000002 00000002 0007FFFF 00000000 00009669
00000003 00000001 00400000 00001234 00000000
00000003 00000002 00000042 00000000 0000F00D
00000001 00000000 00000010 00007777 00000000
00000001 00000003 00000011 00006666 00000000
00000005 00000000 00000000 0000A5C3 00000000
00000004 00000000 00000000 0000A5C3 00000000
00000005 00000000 00000000 00003C5A 00000000
00000000 00000000 00000000 00000000 00000000

// File: verif/bpi_tb.sv
`timescale 1ns/1ns

module bpi_tb;
  logic        CLK, RST, EXECUTE, AL_EXECUTE, AUTO_LOAD_ENA, RUN, BPI_ACTIVE;
  logic [22:0] ADDR, AL_ADDR, BPI_AD;
  logic [15:0] CMD_DATA_OUT, AL_CMD_DATA_OUT, DCFEB_STATUS, CFG_DAT_IN, CFG_DAT_OUT, DATA_IN;
  logic [1:0]  OP, AL_OP;
  logic        CFG_DAT_OE, LOAD_DATA, BUSY, FCS_B, FOE_B, FWE_B, FLATCH_B;

  logic [31:0] gold [0:63];
  logic [2:0]  kind;
  logic [1:0]  exp_op;
  logic [22:0] exp_addr;
  logic [15:0] exp_data, exp_word;
  logic        test_start, test_end, timed_out, display_checked;
  int          tests_run, tests_failed, errors_total, idx;

  bpi_interface_top dut0 (.*);

  bpi_monitor mon0 (.*);

  // Flash read model
  assign CFG_DAT_IN = (FOE_B === 1'b0) ? exp_word : 16'h0000;

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  task automatic wait_busy(logic level, int limit);
    int cnt;
    cnt = 0;
    while (BUSY !== level && cnt < limit) begin
      step();
      cnt++;
    end
    if (BUSY !== level) begin
      $display("Timeout: BUSY did not go to %0b", level);
      timed_out = 1'b1;
    end
  endtask

  task automatic mark_test(input logic start);
    if (start) test_start = 1'b1;
    else test_end = 1'b1;
    step();
    test_start = 1'b0;
    test_end = 1'b0;
  endtask

  task automatic run_flash_cycle();
    if (kind == 3'd2) begin
      AUTO_LOAD_ENA = 1'b1;
      {AL_ADDR, AL_CMD_DATA_OUT, AL_OP} = {exp_addr, exp_data, exp_op};
      {ADDR, CMD_DATA_OUT, OP} = {~exp_addr, ~exp_data, exp_op};
      EXECUTE = 1'b1; // Host strobe must be ignored
      step();
      EXECUTE = 1'b0;
      repeat (2) step();
      AL_EXECUTE = 1'b1;
    end else begin
      {ADDR, CMD_DATA_OUT, OP} = {exp_addr, exp_data, exp_op};
      EXECUTE = 1'b1;
    end
    step();
    {EXECUTE, AL_EXECUTE} = 2'b00;
    wait_busy(1'b1, 10);
    if (kind == 3'd3) begin
      step();
      {ADDR, CMD_DATA_OUT} = {~exp_addr, ~exp_data};
      repeat (2) begin
        EXECUTE = 1'b1;
        step();
        EXECUTE = 1'b0;
        step();
      end
    end
    wait_busy(1'b0, 20);
    repeat (2) step();
    AUTO_LOAD_ENA = 1'b0;
  endtask

  task automatic run_display();
    int cnt;
    RUN = 1'b1;
    step();
    RUN = 1'b0;
    cnt = 0;
    while (!display_checked && cnt < 32 * 3 * 16 + 100) begin
      step();
      cnt++;
    end
    if (!display_checked) begin
      $display("Timeout: startup display did not end");
      timed_out = 1'b1;
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    RST = 1'b1;
    {EXECUTE, AL_EXECUTE, AUTO_LOAD_ENA, RUN, BPI_ACTIVE} = '0;
    {ADDR, AL_ADDR, CMD_DATA_OUT, AL_CMD_DATA_OUT, OP, AL_OP} = '0;
    DCFEB_STATUS = 16'h0000;
    {kind, exp_op, exp_addr, exp_data, exp_word} = '0;
    {test_start, test_end, timed_out} = '0;
    $readmemh("verif/bpi_golden.txt", gold);
    repeat (16) @(posedge CLK);
    #1 RST = 1'b0;
    step();
    idx = 0;
    while (idx < 60 && gold[idx] != 32'd0 && !timed_out) begin
      kind     = gold[idx][2:0];
      exp_op   = gold[idx+1][1:0];
      exp_addr = gold[idx+2][22:0];
      exp_data = gold[idx+3][15:0];
      exp_word = gold[idx+4][15:0];
      if (kind inside {3'd4, 3'd5}) DCFEB_STATUS = exp_data;
      mark_test(1'b1);
      if (kind == 3'd4) run_display();
      else if (kind == 3'd5) repeat (4) step();
      else run_flash_cycle();
      mark_test(1'b0);
      idx += 5;
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors_total);
    if (timed_out || errors_total != 0 || tests_run == 0) begin
      $display("Checks failed");
    end else begin
      $display("All checks passed");
    end
    $finish;
  end

endmodule

// File: verif/bpi_monitor.sv
`timescale 1ns/1ns

module bpi_monitor #(
  parameter int LATCH_CYCLES  = 2,
  parameter int STROBE_CYCLES = 4,
  parameter int ROW_CYCLES    = 16,
  parameter int NUM_PASSES    = 3
) (
  input  logic        CLK,
  input  logic        RST,
  input  logic [2:0]  kind,
  input  logic [1:0]  exp_op,
  input  logic [22:0] exp_addr,
  input  logic [15:0] exp_data,
  input  logic [15:0] exp_word,
  input  logic        test_start,
  input  logic        test_end,
  input  logic        BUSY, FCS_B, FOE_B, FWE_B, FLATCH_B, LOAD_DATA, CFG_DAT_OE, RUN,
  input  logic [22:0] BPI_AD,
  input  logic [15:0] CFG_DAT_OUT,
  input  logic [15:0] DATA_IN,
  output int          tests_run,
  output int          tests_failed,
  output int          errors_total,
  output logic        display_checked
);

  localparam int DISP_LAST = 32 * NUM_PASSES * ROW_CYCLES; // Last sample of the final row

  logic active, prev_busy, disp_run;
  int   test_errs, busy_len, starts, ce_len, we_len, oe_len, lat_len, load_cnt, n, r, k;
  int   ones [16];

  function automatic string kind_name(logic [2:0] kd, logic [1:0] op);
    string base;
    case (kd)
      3'd2:    base = "auto_load";
      3'd3:    base = "busy_execute";
      3'd4:    return "display";
      3'd5:    return "status";
      default: base = "host";
    endcase
    if (op == 2'b01) return {base, "_write"};
    if (op == 2'b10) return {base, "_read"};
    return {base, "_standby"};
  endfunction

  // Bit-on cycles for one channel in one row
  function automatic int ones_expected(int row, int ch);
    int v;
    v = (ROW_CYCLES / 8) * ((row + ch) % 9);
    return (v > ROW_CYCLES) ? ROW_CYCLES : v;
  endfunction

  task automatic compare(string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %h actual %h", kind_name(kind, exp_op), what, exp, act);
      test_errs++;
    end
  endtask

  task automatic fault(string msg);
    $display("Test %s: %s", kind_name(kind, exp_op), msg);
    test_errs++;
  endtask

  initial begin
    tests_run = 0;
    tests_failed = 0;
    errors_total = 0;
    display_checked = 1'b0;
    active = 1'b0;
    prev_busy = 1'b0;
    disp_run = 1'b0;
  end

  //////////////////////////////
  // Sampling at the falling edge
  //////////////////////////////
  always @(negedge CLK) begin
    if (test_start && !RST) begin
      active = 1'b1;
      {test_errs, busy_len, starts, ce_len, we_len, oe_len, lat_len, load_cnt} = '0;
      prev_busy = BUSY;
      disp_run = 1'b0;
      display_checked = 1'b0;
    end else if (active) begin
      case (kind)
        3'd1, 3'd2, 3'd3: begin
          if (BUSY && !prev_busy) starts++;
          prev_busy = BUSY;
          if (BUSY) busy_len++;
          if (!FCS_B) ce_len++;
          if (!FLATCH_B) lat_len++;
          if (!FWE_B) begin
            we_len++;
            compare("BPI_AD", 32'(exp_addr), 32'(BPI_AD));
            compare("CFG_DAT_OUT", 32'(exp_data), 32'(CFG_DAT_OUT));
            compare("CFG_DAT_OE", 32'(1), 32'(CFG_DAT_OE));
          end
          if (!FOE_B) begin
            oe_len++;
            compare("CFG_DAT_OE", 32'(0), 32'(CFG_DAT_OE));
            compare("BPI_AD", 32'(exp_addr), 32'(BPI_AD));
          end
          if (LOAD_DATA) begin
            load_cnt++;
            compare("DATA_IN", 32'(exp_word), 32'(DATA_IN));
          end
        end
        3'd4: begin
          if (!disp_run && !display_checked && RUN) begin
            disp_run = 1'b1;
            n = -1;
          end else if (disp_run) begin
            n++;
            if (n >= 1) begin // Sample 0 is the first load cycle
              r = (n - 1) / ROW_CYCLES;
              k = (n - 1) % ROW_CYCLES;
              if (k == 0) for (int ch = 0; ch < 16; ch++) ones[ch] = 0;
              if (n <= DISP_LAST) begin
                for (int ch = 0; ch < 16; ch++) ones[ch] = ones[ch] + int'(CFG_DAT_OUT[ch]);
              end
              if (k == ROW_CYCLES - 1 && n <= DISP_LAST) begin
                for (int ch = 0; ch < 16; ch++)
                  compare($sformatf("row %0d ch %0d on cycles", r, ch),
                          32'(ones_expected(r % 32, ch)), 32'(ones[ch]));
              end
              if (n == DISP_LAST + 1) begin
                compare("status after display", 32'(exp_data), 32'(CFG_DAT_OUT));
                display_checked = 1'b1;
                disp_run = 1'b0;
              end
            end
          end
        end
        3'd5: begin
          compare("CFG_DAT_OUT", 32'(exp_data), 32'(CFG_DAT_OUT));
          compare("CFG_DAT_OE", 32'(1), 32'(CFG_DAT_OE));
        end
        default: ;
      endcase

      if (test_end) begin
        if (kind inside {3'd1, 3'd2, 3'd3}) begin
          if (starts != 1) fault($sformatf("started %0d flash cycles instead of one", starts));
          compare("BUSY cycles", 32'(LATCH_CYCLES + STROBE_CYCLES + 2), 32'(busy_len));
          compare("FLATCH_B low cycles", 32'(LATCH_CYCLES), 32'(lat_len));
          compare("FCS_B low cycles", 32'(STROBE_CYCLES), 32'(ce_len));
          compare("FWE_B low cycles", 32'((exp_op == 2'b01) ? STROBE_CYCLES : 0), 32'(we_len));
          compare("FOE_B low cycles", 32'((exp_op == 2'b10) ? STROBE_CYCLES : 0), 32'(oe_len));
          compare("LOAD_DATA pulses", 32'((exp_op == 2'b10) ? 1 : 0), 32'(load_cnt));
        end
        if (kind == 3'd4 && !display_checked) fault("display never finished");
        tests_run++;
        errors_total += test_errs;
        if (test_errs != 0) tests_failed++;
        $display("%s: %s (%0d errors)", kind_name(kind, exp_op),
                 (test_errs == 0) ? "PASS" : "FAIL", test_errs);
        active = 1'b0;
      end
    end
  end

endmodule

// File: verif/bpi_checker.sv
`timescale 1ns/1ns

module bpi_checker #(
  parameter int LATCH_CYCLES  = 2,
  parameter int STROBE_CYCLES = 4
) (
  input logic CLK,
  input logic RST,
  input logic busy,
  input logic cap,
  input logic ce,
  input logic oe,
  input logic we,
  input logic latch,
  input logic load
);

  // A new cycle only starts from idle
  a_cap_from_idle: assert property (@(posedge CLK) disable iff (RST) cap |-> !$past(busy))
    else $error("Flash cycle started while busy");
  a_latch_len: assert property (@(posedge CLK) disable iff (RST)
    $rose(ce) |-> $past(latch) && $past(cap, LATCH_CYCLES + 1))
    else $error("Chip enable did not follow a full address latch");
  a_we_len: assert property (@(posedge CLK) disable iff (RST)
    $fell(we) |-> $past(we, STROBE_CYCLES) && !ce)
    else $error("Write enable shorter than the strobe length");
  a_load_last: assert property (@(posedge CLK) disable iff (RST)
    load |-> $past(oe, STROBE_CYCLES - 1))
    else $error("Load strobe not in the last read strobe cycle");
  a_load_end: assert property (@(posedge CLK) disable iff (RST) load |=> busy && !ce)
    else $error("Recover cycle does not follow the load strobe");
  a_busy_len: assert property (@(posedge CLK) disable iff (RST)
    $fell(busy) |-> $past(cap, LATCH_CYCLES + STROBE_CYCLES + 2))
    else $error("Busy length differs from one full flash cycle");
  a_reset: assert property (@(posedge CLK) RST |-> !busy && !ce && !latch && !load)
    else $error("Sequencer active during reset");

endmodule

bind bpi_cycle_fsm bpi_checker #(
  .LATCH_CYCLES(LATCH_CYCLES), .STROBE_CYCLES(STROBE_CYCLES)
) chk0 (
  .CLK(CLK), .RST(RST), .busy(busy), .cap(cap), .ce(ce), .oe(oe),
  .we(we), .latch(latch), .load(load)
);

// File: source/bpi_interface_top.sv
`timescale 1ns/1ns

module bpi_interface_top #(
  parameter int LATCH_CYCLES  = 2,
  parameter int STROBE_CYCLES = 4,
  parameter int ROW_CYCLES    = 16, // Multiple of 8
  parameter int NUM_PASSES    = 3
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  bpi_pkg::flash_addr_t ADDR,
  input  bpi_pkg::flash_data_t CMD_DATA_OUT,
  input  bpi_pkg::bpi_op_t     OP,
  input  logic                 EXECUTE,
  input  bpi_pkg::flash_addr_t AL_ADDR,
  input  bpi_pkg::flash_data_t AL_CMD_DATA_OUT,
  input  bpi_pkg::bpi_op_t     AL_OP,
  input  logic                 AL_EXECUTE,
  input  logic                 AUTO_LOAD_ENA,
  input  logic                 RUN,
  input  logic                 BPI_ACTIVE,
  input  bpi_pkg::flash_data_t DCFEB_STATUS,
  input  bpi_pkg::flash_data_t CFG_DAT_IN,
  output bpi_pkg::flash_data_t CFG_DAT_OUT,
  output logic                 CFG_DAT_OE,
  output bpi_pkg::flash_addr_t BPI_AD,
  output bpi_pkg::flash_data_t DATA_IN,
  output logic                 LOAD_DATA,
  output logic                 BUSY,
  output logic                 FCS_B,
  output logic                 FOE_B,
  output logic                 FWE_B,
  output logic                 FLATCH_B
);
  import bpi_pkg::*;

  logic        execute_sel, cap, rd, wr;
  logic        ce, oe, we, latch;
  logic        load_pat, row_done, display;
  flash_data_t cmd_data, leds, led_word;

  bpi_cmd_if host_cmd ();
  bpi_cmd_if al_cmd ();

  assign host_cmd.addr     = ADDR;
  assign host_cmd.cmd_data = CMD_DATA_OUT;
  assign host_cmd.op       = OP;
  assign host_cmd.execute  = EXECUTE;
  assign al_cmd.addr       = AL_ADDR;
  assign al_cmd.cmd_data   = AL_CMD_DATA_OUT;
  assign al_cmd.op         = AL_OP;
  assign al_cmd.execute    = AL_EXECUTE;

  bpi_cmd_capture cmd0 (
    .CLK(CLK), .RST(RST), .auto_load_ena(AUTO_LOAD_ENA), .host(host_cmd), .al(al_cmd),
    .cap(cap), .execute(execute_sel), .addr(BPI_AD), .cmd_data(cmd_data),
    .read(rd), .write(wr)
  );

  bpi_cycle_fsm #(.LATCH_CYCLES(LATCH_CYCLES), .STROBE_CYCLES(STROBE_CYCLES)) cyc0 (
    .CLK(CLK), .RST(RST), .execute(execute_sel), .read(rd), .write(wr), .busy(BUSY),
    .cap(cap), .ce(ce), .oe(oe), .we(we), .latch(latch), .load(LOAD_DATA)
  );

  startup_display_fsm #(.ROW_CYCLES(ROW_CYCLES)) disp0 (
    .CLK(CLK), .RST(RST), .run(RUN), .row_done(row_done),
    .load_pat(load_pat), .display(display)
  );

  led_pattern_gen #(.NUM_PASSES(NUM_PASSES)) led0 (
    .CLK(CLK), .RST(RST), .load_pat(load_pat), .row_done(row_done), .leds(leds)
  );

  //////////////////////////////
  // Flash pins
  //////////////////////////////
  assign FCS_B    = ~ce;
  assign FOE_B    = ~oe;
  assign FWE_B    = ~we;
  assign FLATCH_B = ~latch;

  assign DATA_IN     = CFG_DAT_IN;
  assign CFG_DAT_OE  = ~oe; // Flash drives the bus during reads
  assign led_word    = display ? leds : DCFEB_STATUS;
  assign CFG_DAT_OUT = (ce | BPI_ACTIVE | AUTO_LOAD_ENA) ? cmd_data : led_word;

endmodule

// File: source/startup_display_fsm.sv
`timescale 1ns/1ns

module startup_display_fsm #(
  parameter int ROW_CYCLES = 16
) (
  input  logic CLK,
  input  logic RST,
  input  logic run,
  input  logic row_done,
  output logic load_pat,
  output logic display
);
  import bpi_pkg::*;

  localparam int CNT_W = $clog2(ROW_CYCLES);

  // Load cycle plus this many hold cycles make one row
  localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(ROW_CYCLES - 2);

  disp_state_t      state;
  logic [CNT_W-1:0] cnt;

  //////////////////////////////
  // Row timing
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= disp_wait_run;
      cnt   <= '0;
    end else begin
      case (state)
        disp_wait_run: begin
          if (run) state <= disp_load;
        end
        disp_load: begin
          state <= disp_hold;
          cnt   <= '0;
        end
        disp_hold: begin
          if (cnt == HOLD_LAST) begin
            // Next row, unless the final pass just ended
            state <= row_done ? disp_done : disp_load;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        disp_done: state <= disp_done; // Status word from here on
        default:   state <= disp_wait_run;
      endcase
    end
  end

  assign load_pat = (state == disp_load);

  // Patterns show one cycle after their load
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      display <= 1'b0;
    end else begin
      display <= (state == disp_load) || (state == disp_hold);
    end
  end

endmodule

// File: source/led_pattern_gen.sv
`timescale 1ns/1ns

module led_pattern_gen #(
  parameter int NUM_PASSES = 3
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 load_pat,
  output logic                 row_done,
  output bpi_pkg::flash_data_t leds
);
  import bpi_pkg::*;

  localparam int PASS_W = $clog2(NUM_PASSES + 1);

  row_addr_t       row;
  logic [PASS_W-1:0] pass_cnt;
  led_pat_t        new_pat [NUM_CHANNELS];
  led_pat_t        pat [NUM_CHANNELS];

  //////////////////////////////
  // Row and pass counters
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row      <= '0;
      pass_cnt <= '0;
    end else if (load_pat) begin
      row <= row + 1'b1; // Wraps to row 0 after the last row
      if ((row == row_addr_t'(NUM_ROWS - 1)) && !row_done) begin
        pass_cnt <= pass_cnt + 1'b1;
      end
    end
  end

  // High once the last row of the final pass is loaded
  assign row_done = (pass_cnt == PASS_W'(NUM_PASSES));

  //////////////////////////////
  // Per-channel patterns
  //////////////////////////////
  always_comb begin
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      new_pat[ch] = pattern_of(duty_of(row, ch));
    end
  end

  // Rotation over a row gives each bit twice its duty in cycles
  always_ff @(posedge CLK) begin
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      if (load_pat) pat[ch] <= new_pat[ch];
      else pat[ch] <= {pat[ch][6:0], pat[ch][7]};
    end
  end

  always_comb begin
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      leds[ch] = pat[ch][0];
    end
  end

endmodule

// File: source/bpi_cycle_fsm.sv
`timescale 1ns/1ns

module bpi_cycle_fsm #(
  parameter int LATCH_CYCLES  = 2,
  parameter int STROBE_CYCLES = 4
) (
  input  logic CLK,
  input  logic RST,
  input  logic execute,
  input  logic read,
  input  logic write,
  output logic busy,
  output logic cap,
  output logic ce,
  output logic oe,
  output logic we,
  output logic latch,
  output logic load
);
  import bpi_pkg::*;

  localparam int MAX_CYCLES = (LATCH_CYCLES > STROBE_CYCLES) ? LATCH_CYCLES : STROBE_CYCLES;
  localparam int CNT_W      = $clog2(MAX_CYCLES) + 1;

  localparam logic [CNT_W-1:0] LATCH_LAST  = CNT_W'(LATCH_CYCLES - 1);
  localparam logic [CNT_W-1:0] STROBE_LAST = CNT_W'(STROBE_CYCLES - 1);

  cycle_state_t     state;
  logic [CNT_W-1:0] cnt;
  logic             rd_op;
  logic             wr_op;

  // Both bits or none means standby, chip enable only
  assign rd_op = read & ~write;
  assign wr_op = write & ~read;

  //////////////////////////////
  // Cycle sequencer
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= cyc_idle;
      cnt   <= '0;
    end else begin
      case (state)
        cyc_idle: begin
          if (execute) state <= cyc_capture; // Pulses while busy are dropped
        end
        cyc_capture: begin
          state <= cyc_latch;
          cnt   <= '0;
        end
        cyc_latch: begin
          if (cnt == LATCH_LAST) begin
            state <= cyc_strobe;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        cyc_strobe: begin
          if (cnt == STROBE_LAST) state <= cyc_recover;
          else cnt <= cnt + 1'b1;
        end
        cyc_recover: state <= cyc_idle;
        default:     state <= cyc_idle;
      endcase
    end
  end

  //////////////////////////////
  // Strobe decode
  //////////////////////////////
  assign busy  = (state != cyc_idle);
  assign cap   = (state == cyc_capture);
  assign latch = (state == cyc_latch);
  assign ce    = (state == cyc_strobe);
  assign oe    = ce & rd_op;
  assign we    = ce & wr_op;
  assign load  = oe & (cnt == STROBE_LAST); // Data settled by last strobe cycle

endmodule

// File: source/bpi_cmd_capture.sv
`timescale 1ns/1ns

module bpi_cmd_capture (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 auto_load_ena,
  bpi_cmd_if.sink              host,
  bpi_cmd_if.sink              al,
  input  logic                 cap,
  output logic                 execute,
  output bpi_pkg::flash_addr_t addr,
  output bpi_pkg::flash_data_t cmd_data,
  output logic                 read,
  output logic                 write
);
  import bpi_pkg::*;

  flash_addr_t sel_addr;
  flash_data_t sel_data;
  bpi_op_t     sel_op;

  //////////////////////////////
  // Command source select
  //////////////////////////////
  always_comb begin
    if (auto_load_ena) begin
      execute  = al.execute;
      sel_addr = al.addr;
      sel_data = al.cmd_data;
      sel_op   = al.op;
    end else begin
      execute  = host.execute;
      sel_addr = host.addr;
      sel_data = host.cmd_data;
      sel_op   = host.op;
    end
  end

  //////////////////////////////
  // Capture on request
  //////////////////////////////
  always_ff @(posedge CLK) begin
    if (cap) begin
      addr     <= sel_addr;
      cmd_data <= sel_data;
    end
  end

  // Op bits steer the strobes, so they start cleared
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      read  <= 1'b0;
      write <= 1'b0;
    end else if (cap) begin
      read  <= sel_op[OP_READ_BIT];
      write <= sel_op[OP_WRITE_BIT];
    end
  end

endmodule

// File: source/bpi_cmd_if.sv
`timescale 1ns/1ns

// One flash command, as issued by a command port
interface bpi_cmd_if;
  import bpi_pkg::*;

  flash_addr_t addr;
  flash_data_t cmd_data;
  bpi_op_t     op;
  logic        execute; // One cycle strobe

  modport source (
    output addr, cmd_data, op, execute
  );

  modport sink (
    input addr, cmd_data, op, execute
  );

endinterface

// File: source/bpi_pkg.sv
package bpi_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////
  typedef logic [22:0] flash_addr_t; // Flash word address
  typedef logic [15:0] flash_data_t; // Command, data or status word
  typedef logic [1:0]  bpi_op_t;     // 01 write, 10 read, else standby
  typedef logic [3:0]  duty_t;
  typedef logic [7:0]  led_pat_t;
  typedef logic [4:0]  row_addr_t;

  localparam int OP_WRITE_BIT = 0;
  localparam int OP_READ_BIT  = 1;

  localparam int NUM_CHANNELS = 16;
  localparam int NUM_ROWS     = 32;
  localparam int DUTY_MOD     = 9;
  localparam int DUTY_FULL    = 8;  // This and above means fully on

  typedef enum logic [2:0] {
    cyc_idle, cyc_capture, cyc_latch, cyc_strobe, cyc_recover
  } cycle_state_t;

  typedef enum logic [1:0] {
    disp_wait_run, disp_load, disp_hold, disp_done
  } disp_state_t;

  // Duty of one channel in one row
  function automatic duty_t duty_of(row_addr_t row, int unsigned ch);
    return duty_t'((int'(row) + ch) % DUTY_MOD);
  endfunction

  // Low d bits set, saturating at fully on
  function automatic led_pat_t pattern_of(duty_t d);
    if (d >= duty_t'(DUTY_FULL)) return '1;
    return (led_pat_t'(1) << d) - led_pat_t'(1);
  endfunction

endpackage
